/* src.f */
hdl/mesh_pkg.sv
hdl/mesh_link_if.sv
hdl/mesh_router.sv
hdl/tile_mem.sv
hdl/mesh_tile.sv
hdl/mesh_array.sv
hdl/host_bridge_fsm.sv
hdl/reply_timer.sv
hdl/mesh_top.sv
tb/tb_mesh_top.sv

/* run.sh */
#!/bin/sh
# builds and runs the mesh testbench with Verilator; exit status follows the result
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
  --top-module tb_mesh_top -f src.f -o sim_mesh
out=$(./obj_dir/sim_mesh)
echo "$out"
echo "$out" | grep -qx "=== PASS ==="

/* tb/tb_mesh_top.sv */
// single Wishbone master with one transfer in flight; expects the default 2x2 grid
`default_nettype none

module tb_mesh_top;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_X = 2;
  localparam int NUM_Y = 2;
  localparam int TIMEOUT = 64;
  // 32 + 64 + 32 + 8 + 32 + 200 + 16 transfers
  localparam int NUM_OPS = 384;
  localparam int CYCLE_LIMIT = NUM_OPS * (TIMEOUT + 20) + 200;

  logic        clk;
  logic        reset;
  logic        cyc;
  logic        stb;
  logic        we;
  logic [6:0]  adr;
  logic [31:0] dat_w;
  logic [31:0] dat_r;
  logic        ack;
  logic        err;

  // one word per tile word, index {row, column, word}
  logic [31:0] model [32];
  // {adr, we, err, data} for each issued transfer, oldest first
  logic [40:0] pending [$];
  int          errors;
  int          done_ops;
  int          cycles;
  int          seed;

  mesh_top #(.NUM_X_P(NUM_X), .NUM_Y_P(NUM_Y), .TIMEOUT_P(TIMEOUT)) UUT (
    .clk_i(clk),
    .reset_i(reset),
    .cyc_i(cyc),
    .stb_i(stb),
    .we_i(we),
    .adr_i(adr),
    .dat_i(dat_w),
    .dat_o(dat_r),
    .ack_o(ack),
    .err_o(err)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // expected {err, data} of a read; rows or columns past the grid never answer
  function automatic logic [32:0] ref_read(input logic [6:0] a);
    if (a[6:5] >= 2'(NUM_Y) || a[4:3] >= 2'(NUM_X)) begin
      return {1'b1, 32'h0};
    end
    return {1'b0, model[{a[5], a[3], a[2:0]}]};
  endfunction

  // in-grid address of model index i
  function automatic logic [6:0] grid_addr(input int i);
    return {1'b0, i[4], 1'b0, i[3], i[2:0]};
  endfunction

  // one Wishbone cycle; no_gap starts the next one without an idle cycle
  task automatic bus_cycle(input logic write, input logic [6:0] a, input logic [31:0] d,
                           input logic no_gap);
    logic [32:0] r;
    r = ref_read(a);
    if (write) begin
      pending.push_back({a, 1'b1, 1'b0, 32'h0});
      if (!r[32]) model[{a[5], a[3], a[2:0]}] = d;
    end else begin
      pending.push_back({a, 1'b0, r});
    end
    cyc = 1'b1;
    stb = 1'b1;
    we = write;
    adr = a;
    dat_w = d;
    do begin
      @(posedge clk);
      #1;
    end while (!(ack || err));
    done_ops++;
    if (!no_gap) begin
      cyc = 1'b0;
      stb = 1'b0;
      @(posedge clk);
      #1;
    end
  endtask

  // outputs are settled mid-cycle
  always @(negedge clk) begin : compare
    logic [40:0] e;
    if (ack === 1'b1 || err === 1'b1) begin
      assert (pending.size() != 0) else begin
        errors++;
        $display("cycle ended at %0t while no transfer was pending", $time);
      end
      if (pending.size() != 0) begin
        e = pending.pop_front();
        assert (err == e[32]) else begin
          errors++;
          $display("MISMATCH err_o adr %h expected %h got %h", e[40:34], e[32], err);
        end
        assert (ack == !e[32]) else begin
          errors++;
          $display("MISMATCH ack_o adr %h expected %h got %h", e[40:34], !e[32], ack);
        end
        if (!e[33]) begin
          assert (dat_r == e[31:0]) else begin
            errors++;
            $display("MISMATCH dat_o adr %h expected %h got %h", e[40:34], e[31:0], dat_r);
          end
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, %0d of %0d transfers done", cycles, done_ops,
               NUM_OPS);
      $display("=== FAIL ===");
      $finish;
    end
  end

  initial begin
    logic [6:0]  a;
    logic [31:0] d;
    logic        w;
    seed = 32'h2560;
    errors = 0;
    done_ops = 0;
    cycles = 0;
    reset = 1'b1;
    cyc = 1'b0;
    stb = 1'b0;
    we = 1'b0;
    adr = '0;
    dat_w = '0;
    for (int i = 0; i < 32; i++) model[i] = '0;
    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;
    // quiet bus while the rows come out of reset
    repeat (5) begin
      @(posedge clk);
      #1;
      assert (ack === 1'b0 && err === 1'b0) else begin
        errors++;
        $display("ack_o or err_o not low while idle after reset");
      end
    end
    for (int i = 0; i < 32; i++) bus_cycle(1'b0, grid_addr(i), 32'h0, 1'b0);
    for (int i = 0; i < 32; i++) begin
      d = $random(seed);
      bus_cycle(1'b1, grid_addr(i), d, 1'b0);
      bus_cycle(1'b0, grid_addr(i), 32'h0, 1'b0);
    end
    // all tiles again, catches writes that landed in the wrong place
    for (int i = 0; i < 32; i++) bus_cycle(1'b0, grid_addr(i), 32'h0, 1'b0);
    bus_cycle(1'b0, 7'b10_00_000, 32'h0, 1'b0);
    bus_cycle(1'b0, 7'b00_10_101, 32'h0, 1'b0);
    bus_cycle(1'b0, 7'b11_11_111, 32'h0, 1'b0);
    bus_cycle(1'b0, 7'b01_11_010, 32'h0, 1'b0);
    bus_cycle(1'b1, 7'b10_00_000, 32'hdead_0001, 1'b0);
    bus_cycle(1'b1, 7'b00_10_101, 32'hdead_0002, 1'b0);
    bus_cycle(1'b1, 7'b11_11_111, 32'hdead_0003, 1'b0);
    bus_cycle(1'b1, 7'b01_11_010, 32'hdead_0004, 1'b0);
    for (int i = 0; i < 32; i++) bus_cycle(1'b0, grid_addr(i), 32'h0, 1'b0);
    for (int i = 0; i < 200; i++) begin
      w = 1'($random(seed));
      a = 7'($random(seed));
      d = $random(seed);
      bus_cycle(w, a, d, 1'b0);
    end
    // burst with no idle cycle between transfers
    for (int j = 0; j < 8; j++) begin
      d = $random(seed);
      bus_cycle(1'b1, grid_addr(j * 4), d, 1'b1);
      bus_cycle(1'b0, grid_addr(j * 4), 32'h0, j != 7);
    end
    repeat (5) @(posedge clk);
    assert (pending.size() == 0) else begin
      errors++;
      $display("%0d transfers never ended", pending.size());
    end
    $display("errors: %0d, transfers done: %0d of %0d", errors, done_ops, NUM_OPS);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* hdl/mesh_top.sv */
// adr_i is {row[1:0], column[1:0], word[2:0]}; out-of-grid reads end in err_o
`default_nettype none

module mesh_top #(
  parameter int NUM_X_P   = 2,
  parameter int NUM_Y_P   = 2,
  parameter int TIMEOUT_P = 64
) (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        cyc_i,
  input  logic                        stb_i,
  input  logic                        we_i,
  input  logic [6:0]                  adr_i,
  input  logic [mesh_pkg::DATA_W-1:0] dat_i,
  output logic [mesh_pkg::DATA_W-1:0] dat_o,
  output logic                        ack_o,
  output logic                        err_o
);

  logic start;
  logic expired;

  mesh_link_if req_link ();
  mesh_link_if rsp_link ();

  host_bridge_fsm bridge (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .cyc_i(cyc_i),
    .stb_i(stb_i),
    .we_i(we_i),
    .adr_i(adr_i),
    .dat_i(dat_i),
    .dat_o(dat_o),
    .ack_o(ack_o),
    .err_o(err_o),
    .req_o(req_link),
    .rsp_i(rsp_link),
    .start_o(start),
    .expired_i(expired)
  );

  reply_timer #(.TIMEOUT_P(TIMEOUT_P)) timer (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .start_i(start),
    .expired_o(expired)
  );

  mesh_array #(.NUM_X_P(NUM_X_P), .NUM_Y_P(NUM_Y_P)) array (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .host_in_i(req_link),
    .host_out_o(rsp_link)
  );

endmodule

`default_nettype wire

/* hdl/reply_timer.sv */
// one-shot countdown; a new start reloads it, expired pulses once per start
`default_nettype none

module reply_timer #(
  parameter int TIMEOUT_P = 64
) (
  input  logic clk_i,
  input  logic reset_i,
  input  logic start_i,
  output logic expired_o
);

  logic [$clog2(TIMEOUT_P+1)-1:0] cnt;
  logic                           active;

  assign expired_o = active && (cnt == '0);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      active <= 1'b0;
      cnt <= '0;
    end else if (start_i) begin
      active <= 1'b1;
      cnt <= ($clog2(TIMEOUT_P+1))'(TIMEOUT_P);
    end else if (active) begin
      if (cnt == '0) active <= 1'b0;
      else cnt <= cnt - 1'b1;
    end
  end

endmodule

`default_nettype wire

/* hdl/host_bridge_fsm.sv */
// Wishbone classic slave; one transfer at a time, writes are posted, read errors return zero
`default_nettype none

module host_bridge_fsm (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      cyc_i,
  input  logic                      stb_i,
  input  logic                      we_i,
  input  logic [6:0]                adr_i,
  input  logic [mesh_pkg::DATA_W-1:0] dat_i,
  output logic [mesh_pkg::DATA_W-1:0] dat_o,
  output logic                      ack_o,
  output logic                      err_o,
  mesh_link_if.tx                   req_o,
  mesh_link_if.rx                   rsp_i,
  output logic                      start_o,
  input  logic                      expired_i
);
  import mesh_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    SEND,
    WAIT_RSP,
    DONE
  } state_e;

  state_e            state;
  logic              ack_q;
  logic              err_q;
  logic [DATA_W-1:0] dat_q;
  logic              sent;

  // packet fields come straight from the held Wishbone inputs
  assign req_o.valid = (state == SEND);
  assign req_o.op = we_i ? OP_STORE : OP_LOAD;
  assign req_o.dest_x = COORD_W'(adr_i[4:3]) + COORD_W'(1);
  assign req_o.dest_y = COORD_W'(adr_i[6:5]);
  assign req_o.src_x = '0;
  assign req_o.src_y = '0;
  assign req_o.word = adr_i[2:0];
  assign req_o.data = dat_i;

  // stray replies are simply dropped
  assign rsp_i.ready = 1'b1;

  assign sent = req_o.valid && req_o.ready;
  assign start_o = sent && !we_i;
  assign ack_o = ack_q;
  assign err_o = err_q;
  assign dat_o = dat_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state <= IDLE;
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      case (state)
        IDLE: if (cyc_i && stb_i) state <= SEND;
        SEND: begin
          if (sent && we_i) begin
            ack_q <= 1'b1;
            state <= DONE;
          end else if (sent) begin
            state <= WAIT_RSP;
          end
        end
        WAIT_RSP: begin
          if (rsp_i.valid) begin
            ack_q <= 1'b1;
            state <= DONE;
          end else if (expired_i) begin
            err_q <= 1'b1;
            state <= DONE;
          end
        end
        default: begin
          ack_q <= 1'b0;
          err_q <= 1'b0;
          state <= IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state == WAIT_RSP && rsp_i.valid) begin
      dat_q <= rsp_i.data;
    end else if (state == WAIT_RSP && expired_i) begin
      dat_q <= '0;
    end
  end

  a_ack_err_excl: assert property (@(posedge clk_i) disable iff (reset_i)
    !(ack_o && err_o));

endmodule

`default_nettype wire

/* hdl/mesh_array.sv */
// tile grid; only row 0 west edge reaches the host, all other edges are tied off or drained
`default_nettype none

module mesh_array #(
  parameter int NUM_X_P = 2,
  parameter int NUM_Y_P = 2
) (
  input  logic    clk_i,
  input  logic    reset_i,
  mesh_link_if.rx host_in_i,
  mesh_link_if.tx host_out_o
);
  import mesh_pkg::*;

  // per tile and direction W, E, N, S
  logic             in_v    [NUM_Y_P][NUM_X_P][4];
  logic             in_r    [NUM_Y_P][NUM_X_P][4];
  logic [PKT_W-1:0] in_pkt  [NUM_Y_P][NUM_X_P][4];
  logic             out_v   [NUM_Y_P][NUM_X_P][4];
  logic             out_r   [NUM_Y_P][NUM_X_P][4];
  logic [PKT_W-1:0] out_pkt [NUM_Y_P][NUM_X_P][4];
  logic             rst_out [NUM_Y_P][NUM_X_P];

  for (genvar r = 0; r < NUM_Y_P; r++) begin : g_row
    for (genvar c = 0; c < NUM_X_P; c++) begin : g_col
      mesh_link_if tin  [4] ();
      mesh_link_if tout [4] ();

      mesh_tile #(.MY_X_P(c + 1), .MY_Y_P(r)) tile (
        .clk_i(clk_i),
        .reset_i(r == 0 ? reset_i : rst_out[(r == 0) ? 0 : r-1][c]),
        .reset_o(rst_out[r][c]),
        .link_in_i(tin),
        .link_out_o(tout)
      );

      for (genvar d = 0; d < 4; d++) begin : g_dir
        // neighbour in direction d, and its facing port
        localparam int NR = r + int'(d == 3) - int'(d == 2);
        localparam int NC = c + int'(d == 1) - int'(d == 0);
        localparam int OD = d ^ 1;

        assign out_v[r][c][d] = tout[d].valid;
        assign out_pkt[r][c][d] = {tout[d].op, tout[d].dest_x, tout[d].dest_y,
                                   tout[d].src_x, tout[d].src_y, tout[d].word, tout[d].data};
        assign tout[d].ready = out_r[r][c][d];
        assign tin[d].valid = in_v[r][c][d];
        assign tin[d].op = op_e'(in_pkt[r][c][d][PKT_W-1 -: OP_W]);
        assign {tin[d].dest_x, tin[d].dest_y, tin[d].src_x, tin[d].src_y, tin[d].word,
                tin[d].data} = in_pkt[r][c][d][PKT_W-OP_W-1:0];
        assign in_r[r][c][d] = tin[d].ready;

        if (NR >= 0 && NR < NUM_Y_P && NC >= 0 && NC < NUM_X_P) begin : g_link
          assign in_v[r][c][d] = out_v[NR][NC][OD];
          assign in_pkt[r][c][d] = out_pkt[NR][NC][OD];
          assign out_r[r][c][d] = in_r[NR][NC][OD];
        end else if (d == 0 && r == 0 && c == 0) begin : g_host
          assign in_v[r][c][d] = host_in_i.valid;
          assign in_pkt[r][c][d] = {host_in_i.op, host_in_i.dest_x, host_in_i.dest_y,
                                    host_in_i.src_x, host_in_i.src_y, host_in_i.word,
                                    host_in_i.data};
          assign host_in_i.ready = in_r[r][c][d];
          assign host_out_o.valid = out_v[r][c][d];
          assign host_out_o.op = op_e'(out_pkt[r][c][d][PKT_W-1 -: OP_W]);
          assign {host_out_o.dest_x, host_out_o.dest_y, host_out_o.src_x, host_out_o.src_y,
                  host_out_o.word, host_out_o.data} = out_pkt[r][c][d][PKT_W-OP_W-1:0];
          assign out_r[r][c][d] = host_out_o.ready;
        end else begin : g_edge
          // nothing enters, anything leaving is drained
          assign in_v[r][c][d] = 1'b0;
          assign in_pkt[r][c][d] = '0;
          assign out_r[r][c][d] = 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/mesh_tile.sv */
// router plus memory; reset is registered once here and passed down the column
`default_nettype none

module mesh_tile #(
  parameter int MY_X_P = 1,
  parameter int MY_Y_P = 0
) (
  input  logic    clk_i,
  input  logic    reset_i,
  output logic    reset_o,
  // index 0..3 is W, E, N, S
  mesh_link_if.rx link_in_i  [4],
  mesh_link_if.tx link_out_o [4]
);

  mesh_link_if rin  [5] ();
  mesh_link_if rout [5] ();

  always_ff @(posedge clk_i) begin
    reset_o <= reset_i;
  end

  // router port g+1 is tile port g, port 0 is local
  for (genvar g = 0; g < 4; g++) begin : g_dir
    assign rin[g+1].valid = link_in_i[g].valid;
    assign rin[g+1].op = link_in_i[g].op;
    assign {rin[g+1].dest_x, rin[g+1].dest_y, rin[g+1].src_x, rin[g+1].src_y,
            rin[g+1].word, rin[g+1].data}
      = {link_in_i[g].dest_x, link_in_i[g].dest_y, link_in_i[g].src_x,
         link_in_i[g].src_y, link_in_i[g].word, link_in_i[g].data};
    assign link_in_i[g].ready = rin[g+1].ready;

    assign link_out_o[g].valid = rout[g+1].valid;
    assign link_out_o[g].op = rout[g+1].op;
    assign {link_out_o[g].dest_x, link_out_o[g].dest_y, link_out_o[g].src_x,
            link_out_o[g].src_y, link_out_o[g].word, link_out_o[g].data}
      = {rout[g+1].dest_x, rout[g+1].dest_y, rout[g+1].src_x, rout[g+1].src_y,
         rout[g+1].word, rout[g+1].data};
    assign rout[g+1].ready = link_out_o[g].ready;
  end

  mesh_router #(.MY_X_P(MY_X_P), .MY_Y_P(MY_Y_P)) router (
    .clk_i(clk_i),
    .reset_i(reset_o),
    .link_in_i(rin),
    .link_out_o(rout)
  );

  tile_mem #(.MY_X_P(MY_X_P), .MY_Y_P(MY_Y_P)) mem (
    .clk_i(clk_i),
    .reset_i(reset_o),
    .req_i(rout[0]),
    .rsp_o(rin[0])
  );

endmodule

`default_nettype wire

/* hdl/tile_mem.sv */
// 8-word tile memory cleared by reset; one load reply in flight at a time
`default_nettype none

module tile_mem #(
  parameter int MY_X_P = 1,
  parameter int MY_Y_P = 0
) (
  input  logic    clk_i,
  input  logic    reset_i,
  mesh_link_if.rx req_i,
  mesh_link_if.tx rsp_o
);
  import mesh_pkg::*;

  logic [DATA_W-1:0]  mem [8];
  logic               rsp_v;
  logic [COORD_W-1:0] rsp_x;
  logic [COORD_W-1:0] rsp_y;
  logic [WORD_W-1:0]  rsp_word;
  logic [DATA_W-1:0]  rsp_data;
  logic               accept;

  // loads wait while the reply register is full
  assign req_i.ready = !(req_i.op == OP_LOAD && rsp_v);
  assign accept = req_i.valid && req_i.ready;

  assign rsp_o.valid = rsp_v;
  assign rsp_o.op = OP_REPLY;
  assign rsp_o.dest_x = rsp_x;
  assign rsp_o.dest_y = rsp_y;
  assign rsp_o.src_x = COORD_W'(MY_X_P);
  assign rsp_o.src_y = COORD_W'(MY_Y_P);
  assign rsp_o.word = rsp_word;
  assign rsp_o.data = rsp_data;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_v <= 1'b0;
      for (int i = 0; i < 8; i++) begin
        mem[i] <= '0;
      end
    end else begin
      if (accept && req_i.op == OP_STORE) begin
        mem[req_i.word] <= req_i.data;
      end
      if (accept && req_i.op == OP_LOAD) begin
        rsp_v <= 1'b1;
      end else if (rsp_o.ready) begin
        rsp_v <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept && req_i.op == OP_LOAD) begin
      rsp_x <= req_i.src_x;
      rsp_y <= req_i.src_y;
      rsp_word <= req_i.word;
      rsp_data <= mem[req_i.word];
    end
  end

  // replies only ever head back to the host
  a_no_reply_in: assert property (@(posedge clk_i) disable iff (reset_i)
    req_i.valid |-> req_i.op != OP_REPLY);

endmodule

`default_nettype wire

/* hdl/mesh_router.sv */
// XY router with one-entry input buffers; column x=1 sends westbound replies north first
`default_nettype none

module mesh_router #(
  parameter int MY_X_P = 1,
  parameter int MY_Y_P = 0
) (
  input  logic     clk_i,
  input  logic     reset_i,
  mesh_link_if.rx  link_in_i  [5],
  mesh_link_if.tx  link_out_o [5]
);
  import mesh_pkg::*;

  localparam int NP = 5;
  localparam int DX_HI = PKT_W - OP_W - 1;
  localparam int DY_HI = DX_HI - COORD_W;

  logic             in_v    [NP];
  logic             in_r    [NP];
  logic [PKT_W-1:0] in_pkt  [NP];
  logic             buf_v   [NP];
  logic [PKT_W-1:0] buf_pkt [NP];
  dir_e             route   [NP];
  logic             leave   [NP];
  // per output, one request bit per input
  logic [NP-1:0]    grant   [NP];
  logic             out_r   [NP];
  logic [PKT_W-1:0] out_pkt [NP];

  for (genvar g = 0; g < NP; g++) begin : g_port
    assign in_v[g] = link_in_i[g].valid;
    assign in_pkt[g] = {link_in_i[g].op, link_in_i[g].dest_x, link_in_i[g].dest_y,
                        link_in_i[g].src_x, link_in_i[g].src_y, link_in_i[g].word,
                        link_in_i[g].data};
    assign link_in_i[g].ready = in_r[g];

    assign link_out_o[g].valid = |grant[g];
    assign link_out_o[g].op = op_e'(out_pkt[g][PKT_W-1 -: OP_W]);
    assign {link_out_o[g].dest_x, link_out_o[g].dest_y, link_out_o[g].src_x,
            link_out_o[g].src_y, link_out_o[g].word, link_out_o[g].data}
      = out_pkt[g][PKT_W-OP_W-1:0];
    assign out_r[g] = link_out_o[g].ready;

    // one winner per output at most
    a_grant_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
      $onehot0(grant[g]));
  end

  // X first, then Y
  always_comb begin
    logic [COORD_W-1:0] dx;
    logic [COORD_W-1:0] dy;
    for (int i = 0; i < NP; i++) begin
      dx = buf_pkt[i][DX_HI -: COORD_W];
      dy = buf_pkt[i][DY_HI -: COORD_W];
      if (dx < COORD_W'(MY_X_P) && !(MY_X_P == 1 && dy != COORD_W'(MY_Y_P))) begin
        route[i] = DIR_W;
      end else if (dx > COORD_W'(MY_X_P)) begin
        route[i] = DIR_E;
      end else if (dy < COORD_W'(MY_Y_P)) begin
        route[i] = DIR_N;
      end else if (dy > COORD_W'(MY_Y_P)) begin
        route[i] = DIR_S;
      end else begin
        route[i] = DIR_P;
      end
    end
  end

  // fixed priority, lowest input wins
  always_comb begin
    for (int o = 0; o < NP; o++) begin
      grant[o] = '0;
      out_pkt[o] = '0;
      for (int i = 0; i < NP; i++) begin
        if (buf_v[i] && route[i] == dir_e'(o) && grant[o] == '0) begin
          grant[o][i] = 1'b1;
          out_pkt[o] = buf_pkt[i];
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < NP; i++) begin
      leave[i] = buf_v[i] && grant[int'(route[i])][i] && out_r[int'(route[i])];
      in_r[i] = !buf_v[i] || leave[i];
    end
  end

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < NP; i++) begin
      if (reset_i) begin
        buf_v[i] <= 1'b0;
      end else if (in_v[i] && in_r[i]) begin
        buf_v[i] <= 1'b1;
      end else if (leave[i]) begin
        buf_v[i] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < NP; i++) begin
      if (in_v[i] && in_r[i]) begin
        buf_pkt[i] <= in_pkt[i];
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/mesh_link_if.sv */
// one-direction packet hop; a packet moves on an edge with valid and ready both high
`default_nettype none

interface mesh_link_if;
  import mesh_pkg::*;

  logic               valid;
  logic               ready;
  op_e                op;
  logic [COORD_W-1:0] dest_x;
  logic [COORD_W-1:0] dest_y;
  logic [COORD_W-1:0] src_x;
  logic [COORD_W-1:0] src_y;
  logic [WORD_W-1:0]  word;
  logic [DATA_W-1:0]  data;

  modport tx (output valid, op, dest_x, dest_y, src_x, src_y, word, data, input ready);
  modport rx (input valid, op, dest_x, dest_y, src_x, src_y, word, data, output ready);

endinterface

`default_nettype wire

/* hdl/mesh_pkg.sv */
// shared widths and enums; packets are word-addressed and the router uses XY routing
`default_nettype none

package mesh_pkg;

  // one router coordinate, x=0 is the host bridge column
  localparam int COORD_W = 3;
  // 8 words per tile memory
  localparam int WORD_W = 3;
  localparam int DATA_W = 32;

  // flattened packet as {op, dest_x, dest_y, src_x, src_y, word, data}
  localparam int OP_W = 2;
  localparam int PKT_W = OP_W + 4 * COORD_W + WORD_W + DATA_W;

  typedef enum logic [1:0] {
    OP_STORE = 2'd0,
    OP_LOAD  = 2'd1,
    OP_REPLY = 2'd2
  } op_e;

  // router port order, also the arbitration priority
  typedef enum logic [2:0] {
    DIR_P = 3'd0,
    DIR_W = 3'd1,
    DIR_E = 3'd2,
    DIR_N = 3'd3,
    DIR_S = 3'd4
  } dir_e;

endpackage

`default_nettype wire
